// ==== compile.f ====
hdl/rv_isa_pkg.sv
hdl/exu_info_pkg.sv
hdl/exu_op_decode.sv
hdl/exu_alu.sv
hdl/exu_bjp.sv
hdl/exu_result_queue.sv
hdl/exu_top.sv
verification/exu_tb.sv

// ==== hdl/exu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_alu
  import rv_isa_pkg::*;
(
  input  wire  [XLEN-1:0] op1_i,
  input  wire  [XLEN-1:0] op2_i,
  input  wire             op_add_i,
  input  wire             op_sub_i,
  input  wire             op_sll_i,
  input  wire             op_srl_i,
  input  wire             op_sra_i,
  input  wire             op_slt_i,
  input  wire             op_sltu_i,
  input  wire             op_xor_i,
  input  wire             op_or_i,
  input  wire             op_and_i,
  input  wire             op_lui_i,
  input  wire             op_mul_i,
  input  wire             wop_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_eq_o,
  output logic            cmp_lt_o,
  output logic            cmp_ltu_o
);

  logic [XLEN-1:0] adder_in2;
  logic [XLEN-1:0] sum;
  logic            carry;
  logic [5:0]      shamt;
  logic [XLEN-1:0] sll_full;
  logic [XLEN-1:0] srl_full;
  logic [XLEN-1:0] sra_full;
  logic [XLEN-1:0] mul_full;
  logic [31:0]     srlw;
  logic [31:0]     sraw;
  logic [XLEN-1:0] sum_res;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [XLEN-1:0] mul_res;
  logic            sel_sum;
  logic [10:0]     sel;

  function automatic logic [XLEN-1:0] sext_w(input logic [31:0] v);
    return {{(XLEN-32){v[31]}}, v};
  endfunction

  // shared adder, subtract is op1 + ~op2 + 1
  assign adder_in2      = op_sub_i ? ~op2_i : op2_i;
  assign {carry, sum}   = {1'b0, op1_i} + {1'b0, adder_in2} + {{XLEN{1'b0}}, op_sub_i};

  // compare flags, only meaningful in subtract mode
  assign cmp_eq_o  = (sum == '0);
  assign cmp_ltu_o = ~carry;
  assign cmp_lt_o  = (op1_i[XLEN-1] & ~op2_i[XLEN-1]) |
                     (~(op1_i[XLEN-1] ^ op2_i[XLEN-1]) & sum[XLEN-1]);

  assign shamt    = op2_i[5:0];
  assign sll_full = op1_i << shamt;
  assign srl_full = op1_i >> shamt;
  assign sra_full = $signed(op1_i) >>> shamt;
  assign mul_full = op1_i * op2_i;

  // right shifts of a word need the 32-bit operand
  assign srlw = op1_i[31:0] >> shamt;
  assign sraw = $signed(op1_i[31:0]) >>> shamt;

  assign sum_res = wop_i ? sext_w(sum[31:0]) : sum;
  assign sll_res = wop_i ? sext_w(sll_full[31:0]) : sll_full;
  assign srl_res = wop_i ? sext_w(srlw) : srl_full;
  assign sra_res = wop_i ? sext_w(sraw) : sra_full;
  assign mul_res = wop_i ? sext_w(mul_full[31:0]) : mul_full;

  // compares drive the subtractor but return only a flag
  assign sel_sum = (op_add_i | op_sub_i) & ~op_slt_i & ~op_sltu_i;
  assign sel     = {sel_sum, op_sll_i, op_srl_i, op_sra_i, op_slt_i, op_sltu_i,
                    op_xor_i, op_or_i, op_and_i, op_lui_i, op_mul_i};

  assign result_o = ({XLEN{sel_sum}}   & sum_res) |
                    ({XLEN{op_sll_i}}  & sll_res) |
                    ({XLEN{op_srl_i}}  & srl_res) |
                    ({XLEN{op_sra_i}}  & sra_res) |
                    ({XLEN{op_slt_i}}  & {{(XLEN-1){1'b0}}, cmp_lt_o}) |
                    ({XLEN{op_sltu_i}} & {{(XLEN-1){1'b0}}, cmp_ltu_o}) |
                    ({XLEN{op_xor_i}}  & (op1_i ^ op2_i)) |
                    ({XLEN{op_or_i}}   & (op1_i | op2_i)) |
                    ({XLEN{op_and_i}}  & (op1_i & op2_i)) |
                    ({XLEN{op_lui_i}}  & op2_i) |
                    ({XLEN{op_mul_i}}  & mul_res);

  // decode must never select two results at once
  always_comb begin
    assert final ($onehot0(sel))
      else $error("exu_alu: more than one result strobe active");
  end

endmodule

`default_nettype wire

// ==== hdl/exu_bjp.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_bjp
  import rv_isa_pkg::*;
  import exu_info_pkg::*;
(
  input  wire                  op_jal_i,
  input  wire                  op_jalr_i,
  input  wire [BR_COND_W-1:0]  br_cond_i,
  input  wire                  cmp_eq_i,
  input  wire                  cmp_lt_i,
  input  wire                  cmp_ltu_i,
  input  wire [XLEN-1:0]       jp_op1_i,
  input  wire [XLEN-1:0]       jp_op2_i,
  output logic                 jump_o,
  output logic [XLEN-1:0]      jump_addr_o
);

  logic            br_taken;
  logic [XLEN-1:0] target;

  // compare flags come from the alu subtractor
  always_comb begin
    case (br_cond_i)
      BR_EQ:   br_taken = cmp_eq_i;
      BR_NE:   br_taken = ~cmp_eq_i;
      BR_LT:   br_taken = cmp_lt_i;
      BR_GE:   br_taken = ~cmp_lt_i;
      BR_LTU:  br_taken = cmp_ltu_i;
      BR_GEU:  br_taken = ~cmp_ltu_i;
      default: br_taken = 1'b0;
    endcase
  end

  assign jump_o = op_jal_i | op_jalr_i | br_taken;

  // jalr clears bit 0 of the target
  assign target      = jp_op1_i + jp_op2_i;
  assign jump_addr_o = {target[XLEN-1:1], target[0] & ~op_jalr_i};

endmodule

`default_nettype wire

// ==== hdl/exu_info_pkg.sv ====
`default_nettype none

package exu_info_pkg;

  localparam int CLASS_W   = 3;
  localparam int BR_COND_W = 3;

  // low 3 bits of the info word, everything else is illegal
  typedef enum logic [CLASS_W-1:0] {
    CLS_ALU = 3'd1,
    CLS_BJP = 3'd2,
    CLS_LS  = 3'd3,
    CLS_MDU = 3'd4
  } exu_class_e;

  // branch condition codes, decode to branch unit
  localparam logic [BR_COND_W-1:0] BR_NONE = 3'd0;
  localparam logic [BR_COND_W-1:0] BR_EQ   = 3'd1;
  localparam logic [BR_COND_W-1:0] BR_NE   = 3'd2;
  localparam logic [BR_COND_W-1:0] BR_LT   = 3'd3;
  localparam logic [BR_COND_W-1:0] BR_GE   = 3'd4;
  localparam logic [BR_COND_W-1:0] BR_LTU  = 3'd5;
  localparam logic [BR_COND_W-1:0] BR_GEU  = 3'd6;

  // views of the 13 op bits, add at bit 15 of the info word
  typedef struct packed {
    logic add;
    logic sub;
    logic sll;
    logic srl;
    logic sra;
    logic slt;
    logic sltu;
    logic xor_op;
    logic or_op;
    logic and_op;
    logic lui;
    logic wop;
    logic pad;
  } exu_alu_info_t;

  typedef struct packed {
    logic       jal;
    logic       jalr;
    logic       beq;
    logic       bne;
    logic       blt;
    logic       bge;
    logic       bltu;
    logic       bgeu;
    logic [4:0] pad;
  } exu_bjp_info_t;

  typedef struct packed {
    logic       load;
    logic       store;
    logic       usign;
    logic       sz_byte;
    logic       sz_db;
    logic       sz_word;
    logic       sz_dw;
    logic [5:0] pad;
  } exu_ls_info_t;

  // only mul is executed, the rest are flagged illegal
  typedef struct packed {
    logic       mul;
    logic       mulh;
    logic       mulhsu;
    logic       mulhu;
    logic       div;
    logic       divu;
    logic       rem;
    logic       remu;
    logic       wop;
    logic [3:0] pad;
  } exu_mdu_info_t;

  // the class field picks which view is valid
  typedef union packed {
    exu_alu_info_t alu;
    exu_bjp_info_t bjp;
    exu_ls_info_t  ls;
    exu_mdu_info_t mdu;
  } exu_info_u;

  typedef struct packed {
    exu_info_u  op;
    exu_class_e cls;
  } exu_info_t;

endpackage

`default_nettype wire

// ==== hdl/exu_op_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_op_decode
  import rv_isa_pkg::*;
  import exu_info_pkg::*;
(
  input  wire exu_info_t        info_i,
  output logic                  op_add_o,
  output logic                  op_sub_o,
  output logic                  op_sll_o,
  output logic                  op_srl_o,
  output logic                  op_sra_o,
  output logic                  op_slt_o,
  output logic                  op_sltu_o,
  output logic                  op_xor_o,
  output logic                  op_or_o,
  output logic                  op_and_o,
  output logic                  op_lui_o,
  output logic                  op_mul_o,
  output logic                  wop_o,
  output logic                  op_jal_o,
  output logic                  op_jalr_o,
  output logic [BR_COND_W-1:0]  br_cond_o,
  output ls_info_t              ls_info_o,
  output logic                  illegal_o
);

  exu_info_u op;
  logic      alu_req;
  logic      bjp_req;
  logic      ls_req;
  logic      mdu_req;
  logic      br_req;
  logic      mdu_other;

  assign op      = info_i.op;
  assign alu_req = (info_i.cls == CLS_ALU);
  assign bjp_req = (info_i.cls == CLS_BJP);
  assign ls_req  = (info_i.cls == CLS_LS);
  assign mdu_req = (info_i.cls == CLS_MDU);

  assign op_jal_o  = bjp_req & op.bjp.jal;
  assign op_jalr_o = bjp_req & op.bjp.jalr;
  assign br_req    = bjp_req & (|{op.bjp.beq, op.bjp.bne, op.bjp.blt,
                                  op.bjp.bge, op.bjp.bltu, op.bjp.bgeu});

  // jumps and address generation share the adder in add mode
  assign op_add_o = (alu_req & op.alu.add) | op_jal_o | op_jalr_o | ls_req;
  // every compare runs the adder as a subtractor
  assign op_sub_o = (alu_req & (op.alu.sub | op.alu.slt | op.alu.sltu)) | br_req;

  assign op_sll_o  = alu_req & op.alu.sll;
  assign op_srl_o  = alu_req & op.alu.srl;
  assign op_sra_o  = alu_req & op.alu.sra;
  assign op_slt_o  = alu_req & op.alu.slt;
  assign op_sltu_o = alu_req & op.alu.sltu;
  assign op_xor_o  = alu_req & op.alu.xor_op;
  assign op_or_o   = alu_req & op.alu.or_op;
  assign op_and_o  = alu_req & op.alu.and_op;
  assign op_lui_o  = alu_req & op.alu.lui;

  // mdu ops outside of mul
  assign mdu_other = |{op.mdu.mulh, op.mdu.mulhsu, op.mdu.mulhu, op.mdu.div,
                       op.mdu.divu, op.mdu.rem, op.mdu.remu};
  assign op_mul_o  = mdu_req & op.mdu.mul & ~mdu_other;
  assign wop_o     = (alu_req & op.alu.wop) | (mdu_req & op.mdu.wop);

  always_comb begin
    br_cond_o = BR_NONE;
    if (bjp_req) begin
      if (op.bjp.beq)
        br_cond_o = BR_EQ;
      else if (op.bjp.bne)
        br_cond_o = BR_NE;
      else if (op.bjp.blt)
        br_cond_o = BR_LT;
      else if (op.bjp.bge)
        br_cond_o = BR_GE;
      else if (op.bjp.bltu)
        br_cond_o = BR_LTU;
      else if (op.bjp.bgeu)
        br_cond_o = BR_GEU;
    end
  end

  assign ls_info_o.load     = ls_req & op.ls.load;
  assign ls_info_o.store    = ls_req & op.ls.store;
  assign ls_info_o.usign    = ls_req & op.ls.usign;
  assign ls_info_o.sz_byte  = ls_req & op.ls.sz_byte;
  assign ls_info_o.sz_half  = ls_req & op.ls.sz_db;
  assign ls_info_o.sz_word  = ls_req & op.ls.sz_word;
  assign ls_info_o.sz_dword = ls_req & op.ls.sz_dw;

  assign illegal_o = ~(alu_req | bjp_req | ls_req | mdu_req) |
                     (mdu_req & (~op.mdu.mul | mdu_other));

endmodule

`default_nettype wire

// ==== hdl/exu_result_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_result_queue
  import rv_isa_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4,
  parameter int WB_CREDITS  = 2
) (
  input  wire                  clk,
  input  wire                  reset_i,
  input  wire                  push_i,
  input  wire                  push_rd_wr_en_i,
  input  wire [REG_IDX_W-1:0]  push_rd_idx_i,
  input  wire [XLEN-1:0]       push_result_i,
  input  wire ls_info_t        push_ls_info_i,
  input  wire [XLEN-1:0]       push_store_data_i,
  input  wire                  push_jump_i,
  input  wire [XLEN-1:0]       push_jump_addr_i,
  input  wire                  push_illegal_i,
  input  wire                  wb_credit_i,
  output logic                 issue_credit_o,
  output logic                 wb_valid_o,
  output logic                 wb_rd_wr_en_o,
  output logic [REG_IDX_W-1:0] wb_rd_idx_o,
  output logic [XLEN-1:0]      wb_result_o,
  output ls_info_t             wb_ls_info_o,
  output logic [XLEN-1:0]      wb_store_data_o,
  output logic                 wb_jump_o,
  output logic [XLEN-1:0]      wb_jump_addr_o,
  output logic                 wb_illegal_o
);

  localparam int PTR_W   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W   = $clog2(QUEUE_DEPTH + 1);
  // one spare count so an extra credit shows up instead of wrapping
  localparam int CRD_W   = $clog2(WB_CREDITS + 2);
  localparam int ENTRY_W = 3 * XLEN + REG_IDX_W + $bits(ls_info_t) + 3;

  logic [ENTRY_W-1:0] mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic [CRD_W-1:0]   credits;
  logic               pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // head leaves as soon as writeback has room for it
  assign pop        = (count != '0) && (credits != '0);
  assign wb_valid_o = pop;

  assign {wb_rd_wr_en_o, wb_rd_idx_o, wb_result_o, wb_ls_info_o,
          wb_store_data_o, wb_jump_o, wb_jump_addr_o, wb_illegal_o} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= {push_rd_wr_en_i, push_rd_idx_i, push_result_i, push_ls_info_i,
                      push_store_data_i, push_jump_i, push_jump_addr_i, push_illegal_i};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      credits        <= CRD_W'(WB_CREDITS);
      issue_credit_o <= 1'b0;
    end else begin
      if (push_i)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      count          <= count + CNT_W'(push_i) - CNT_W'(pop);
      credits        <= credits + CRD_W'(wb_credit_i) - CRD_W'(pop);
      // freed slot goes back upstream one cycle later
      issue_credit_o <= pop;
    end
  end

  // upstream spends a credit per push, so a full queue means a lost credit
  push_not_full: assert property (@(posedge clk) disable iff (reset_i)
    push_i |-> (count < CNT_W'(QUEUE_DEPTH)))
    else $error("exu_result_queue: push while full");

  credit_bound: assert property (@(posedge clk) disable iff (reset_i)
    credits <= CRD_W'(WB_CREDITS))
    else $error("exu_result_queue: writeback returned more credits than issued");

endmodule

`default_nettype wire

// ==== hdl/exu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_top
  import rv_isa_pkg::*;
  import exu_info_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4,
  parameter int WB_CREDITS  = 2
) (
  input  wire                  clk,
  input  wire                  reset_i,
  input  wire                  issue_valid_i,
  input  wire                  rd_wr_en_i,
  input  wire [REG_IDX_W-1:0]  rd_idx_i,
  input  wire [XLEN-1:0]       op1_i,
  input  wire [XLEN-1:0]       op2_i,
  input  wire [XLEN-1:0]       jp_op1_i,
  input  wire [XLEN-1:0]       jp_op2_i,
  input  wire exu_info_t       info_i,
  output logic                 issue_credit_o,
  input  wire                  wb_credit_i,
  output logic                 wb_valid_o,
  output logic                 wb_rd_wr_en_o,
  output logic [REG_IDX_W-1:0] wb_rd_idx_o,
  output logic [XLEN-1:0]      wb_result_o,
  output ls_info_t             wb_ls_info_o,
  output logic [XLEN-1:0]      wb_store_data_o,
  output logic                 wb_jump_o,
  output logic [XLEN-1:0]      wb_jump_addr_o,
  output logic                 wb_illegal_o
);

  logic op_add, op_sub, op_sll, op_srl, op_sra, op_slt, op_sltu;
  logic op_xor, op_or, op_and, op_lui, op_mul, wop;
  logic op_jal, op_jalr;
  logic [BR_COND_W-1:0] br_cond;
  ls_info_t             ls_info;
  logic                 illegal;
  logic [XLEN-1:0]      alu_result;
  logic                 cmp_eq, cmp_lt, cmp_ltu;
  logic                 jump;
  logic [XLEN-1:0]      jump_addr;
  logic [XLEN-1:0]      store_data;

  exu_op_decode i_decode (
    .info_i    (info_i),
    .op_add_o  (op_add),
    .op_sub_o  (op_sub),
    .op_sll_o  (op_sll),
    .op_srl_o  (op_srl),
    .op_sra_o  (op_sra),
    .op_slt_o  (op_slt),
    .op_sltu_o (op_sltu),
    .op_xor_o  (op_xor),
    .op_or_o   (op_or),
    .op_and_o  (op_and),
    .op_lui_o  (op_lui),
    .op_mul_o  (op_mul),
    .wop_o     (wop),
    .op_jal_o  (op_jal),
    .op_jalr_o (op_jalr),
    .br_cond_o (br_cond),
    .ls_info_o (ls_info),
    .illegal_o (illegal)
  );

  exu_alu i_alu (
    .op1_i     (op1_i),
    .op2_i     (op2_i),
    .op_add_i  (op_add),
    .op_sub_i  (op_sub),
    .op_sll_i  (op_sll),
    .op_srl_i  (op_srl),
    .op_sra_i  (op_sra),
    .op_slt_i  (op_slt),
    .op_sltu_i (op_sltu),
    .op_xor_i  (op_xor),
    .op_or_i   (op_or),
    .op_and_i  (op_and),
    .op_lui_i  (op_lui),
    .op_mul_i  (op_mul),
    .wop_i     (wop),
    .result_o  (alu_result),
    .cmp_eq_o  (cmp_eq),
    .cmp_lt_o  (cmp_lt),
    .cmp_ltu_o (cmp_ltu)
  );

  exu_bjp i_bjp (
    .op_jal_i    (op_jal),
    .op_jalr_i   (op_jalr),
    .br_cond_i   (br_cond),
    .cmp_eq_i    (cmp_eq),
    .cmp_lt_i    (cmp_lt),
    .cmp_ltu_i   (cmp_ltu),
    .jp_op1_i    (jp_op1_i),
    .jp_op2_i    (jp_op2_i),
    .jump_o      (jump),
    .jump_addr_o (jump_addr)
  );

  // rs2 value rides on the second jump operand for stores
  assign store_data = ls_info.store ? jp_op2_i : '0;

  exu_result_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .WB_CREDITS  (WB_CREDITS)
  ) i_queue (
    .clk               (clk),
    .reset_i           (reset_i),
    .push_i            (issue_valid_i),
    .push_rd_wr_en_i   (rd_wr_en_i),
    .push_rd_idx_i     (rd_idx_i),
    .push_result_i     (alu_result),
    .push_ls_info_i    (ls_info),
    .push_store_data_i (store_data),
    .push_jump_i       (jump),
    .push_jump_addr_i  (jump_addr),
    .push_illegal_i    (illegal),
    .wb_credit_i       (wb_credit_i),
    .issue_credit_o    (issue_credit_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rd_wr_en_o     (wb_rd_wr_en_o),
    .wb_rd_idx_o       (wb_rd_idx_o),
    .wb_result_o       (wb_result_o),
    .wb_ls_info_o      (wb_ls_info_o),
    .wb_store_data_o   (wb_store_data_o),
    .wb_jump_o         (wb_jump_o),
    .wb_jump_addr_o    (wb_jump_addr_o),
    .wb_illegal_o      (wb_illegal_o)
  );

endmodule

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  // integer register width
  localparam int XLEN      = 64;
  localparam int REG_IDX_W = 5;

  // one memory access as seen by the load/store unit
  // load sits in bit 0, access size flags in the upper bits
  typedef struct packed {
    logic sz_dword;
    logic sz_word;
    logic sz_half;
    logic sz_byte;
    logic usign;
    logic store;
    logic load;
  } ls_info_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module exu_tb -f compile.f -Mdir obj_dir -o exu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/exu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "no result line found in $LOG"
  exit 1
fi
exit 0

// ==== verification/exu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_tb;

  localparam int QUEUE_DEPTH = 4;
  localparam int WB_CREDITS  = 2;
  localparam int MAX_TESTS   = 48;

  // class codes in the low 3 bits of the info word
  localparam logic [2:0] C_ALU = 3'd1;
  localparam logic [2:0] C_BJP = 3'd2;
  localparam logic [2:0] C_LS  = 3'd3;
  localparam logic [2:0] C_MDU = 3'd4;
  localparam logic [2:0] C_BAD = 3'd5;

  // bit positions inside the 13-bit op field with the first flag on top
  localparam int OP_ADD   = 12;
  localparam int OP_SUB   = 11;
  localparam int OP_SLL   = 10;
  localparam int OP_SRL   = 9;
  localparam int OP_SRA   = 8;
  localparam int OP_SLT   = 7;
  localparam int OP_SLTU  = 6;
  localparam int OP_XOR   = 5;
  localparam int OP_OR    = 4;
  localparam int OP_AND   = 3;
  localparam int OP_LUI   = 2;
  localparam int OP_WOP   = 1;
  localparam int OP_JAL   = 12;
  localparam int OP_JALR  = 11;
  localparam int OP_BEQ   = 10;
  localparam int OP_BNE   = 9;
  localparam int OP_BLT   = 8;
  localparam int OP_BGE   = 7;
  localparam int OP_BLTU  = 6;
  localparam int OP_BGEU  = 5;
  localparam int OP_LOAD  = 12;
  localparam int OP_STORE = 11;
  localparam int OP_USIGN = 10;
  localparam int OP_BYTE  = 9;
  localparam int OP_WORD  = 7;
  localparam int OP_DWORD = 6;
  localparam int OP_MUL   = 12;
  localparam int OP_DIV   = 8;
  localparam int OP_MWOP  = 4;

  logic        clk;
  logic        reset_i;
  logic        issue_valid_i;
  logic        rd_wr_en_i;
  logic [4:0]  rd_idx_i;
  logic [63:0] op1_i;
  logic [63:0] op2_i;
  logic [63:0] jp_op1_i;
  logic [63:0] jp_op2_i;
  logic [15:0] info_i;
  logic        issue_credit_o;
  logic        wb_credit_i;
  logic        wb_valid_o;
  logic        wb_rd_wr_en_o;
  logic [4:0]  wb_rd_idx_o;
  logic [63:0] wb_result_o;
  logic [6:0]  wb_ls_info_o;
  logic [63:0] wb_store_data_o;
  logic        wb_jump_o;
  logic [63:0] wb_jump_addr_o;
  logic        wb_illegal_o;

  // one row of stimulus and expected values per test
  string       t_name [MAX_TESTS];
  logic [15:0] t_info [MAX_TESTS];
  logic [63:0] t_op1  [MAX_TESTS];
  logic [63:0] t_op2  [MAX_TESTS];
  logic [63:0] t_jp1  [MAX_TESTS];
  logic [63:0] t_jp2  [MAX_TESTS];
  logic [4:0]  t_rd   [MAX_TESTS];
  logic [63:0] t_res  [MAX_TESTS];
  logic        t_jump [MAX_TESTS];
  logic [63:0] t_tgt  [MAX_TESTS];
  logic [6:0]  t_ls   [MAX_TESTS];
  logic [63:0] t_sd   [MAX_TESTS];
  logic        t_ill  [MAX_TESTS];

  integer seed;
  int     n_tests;
  int     next_issue;
  int     exp_idx;
  int     passed;
  int     failed;
  int     other_errs;
  int     issue_credits;
  int     outstanding;
  int     credit_pulses;
  int     cycle;
  int     limit;
  int     tail;
  logic   timed_out;

  exu_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .WB_CREDITS  (WB_CREDITS)
  ) i_dut (
    .clk             (clk),
    .reset_i         (reset_i),
    .issue_valid_i   (issue_valid_i),
    .rd_wr_en_i      (rd_wr_en_i),
    .rd_idx_i        (rd_idx_i),
    .op1_i           (op1_i),
    .op2_i           (op2_i),
    .jp_op1_i        (jp_op1_i),
    .jp_op2_i        (jp_op2_i),
    .info_i          (info_i),
    .issue_credit_o  (issue_credit_o),
    .wb_credit_i     (wb_credit_i),
    .wb_valid_o      (wb_valid_o),
    .wb_rd_wr_en_o   (wb_rd_wr_en_o),
    .wb_rd_idx_o     (wb_rd_idx_o),
    .wb_result_o     (wb_result_o),
    .wb_ls_info_o    (wb_ls_info_o),
    .wb_store_data_o (wb_store_data_o),
    .wb_jump_o       (wb_jump_o),
    .wb_jump_addr_o  (wb_jump_addr_o),
    .wb_illegal_o    (wb_illegal_o)
  );

  always #20 clk = ~clk;

  function automatic logic [15:0] make_info(input logic [2:0] cls, input int b0,
                                            input int b1, input int b2);
    logic [12:0] op;
    op = '0;
    if (b0 >= 0)
      op = op | (13'd1 << b0);
    if (b1 >= 0)
      op = op | (13'd1 << b1);
    if (b2 >= 0)
      op = op | (13'd1 << b2);
    return {op, cls};
  endfunction

  function automatic logic [63:0] sign_extend_word(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  task automatic put_entry(input string name, input logic [15:0] info,
                           input logic [63:0] a, input logic [63:0] b,
                           input logic [63:0] jp1, input logic [63:0] jp2,
                           input logic [4:0] rd, input logic [63:0] res,
                           input logic jump, input logic [63:0] tgt,
                           input logic [6:0] ls, input logic [63:0] sd, input logic ill);
    t_name[n_tests] = name;
    t_info[n_tests] = info;
    t_op1[n_tests]  = a;
    t_op2[n_tests]  = b;
    t_jp1[n_tests]  = jp1;
    t_jp2[n_tests]  = jp2;
    t_rd[n_tests]   = rd;
    t_res[n_tests]  = res;
    t_jump[n_tests] = jump;
    t_tgt[n_tests]  = tgt;
    t_ls[n_tests]   = ls;
    t_sd[n_tests]   = sd;
    t_ill[n_tests]  = ill;
    n_tests++;
  endtask

  task automatic alu_entry(input string name, input logic [15:0] info,
                           input logic [63:0] a, input logic [63:0] b, input logic [63:0] res);
    put_entry(name, info, a, b, 64'd0, 64'd0, 5'(n_tests % 31 + 1), res,
              1'b0, 64'd0, 7'd0, 64'd0, 1'b0);
  endtask

  // branches run the adder as a subtractor and target pc plus offset
  task automatic branch_entry(input string name, input int cond_bit,
                              input logic [63:0] x, input logic [63:0] y, input logic taken);
    logic [63:0] pc;
    logic [63:0] off;
    pc  = 64'h0000_0000_8000_0100;
    off = 64'(n_tests) << 2;
    put_entry(name, make_info(C_BJP, cond_bit, -1, -1), x, y, pc, off, 5'd0, x - y,
              taken, pc + off, 7'd0, 64'd0, 1'b0);
  endtask

  task automatic load_table();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] neg;
    logic [63:0] pos;
    logic [63:0] sa;
    logic [63:0] pc;
    logic [63:0] rs1;
    logic [63:0] base;
    logic [63:0] data;
    a    = 64'h0123_4567_89ab_cdef;
    b    = 64'hfedc_ba98_0f1e_2d3c;
    neg  = 64'hffff_ffff_ffff_fffd;
    pos  = 64'd2;
    sa   = 64'h8000_0000_f000_0001;
    pc   = 64'h0000_0000_8000_0100;
    rs1  = 64'h0000_0000_8000_2001;
    base = 64'h0000_0000_0001_0000;
    data = 64'hdead_beef_0bad_f00d;

    alu_entry("add", make_info(C_ALU, OP_ADD, -1, -1), a, b, a + b);
    alu_entry("sub", make_info(C_ALU, OP_SUB, -1, -1), a, b, a - b);
    alu_entry("addw", make_info(C_ALU, OP_ADD, OP_WOP, -1), a, b,
              sign_extend_word(a[31:0] + b[31:0]));
    alu_entry("xor", make_info(C_ALU, OP_XOR, -1, -1), a, b, a ^ b);
    alu_entry("or", make_info(C_ALU, OP_OR, -1, -1), a, b, a | b);
    alu_entry("and", make_info(C_ALU, OP_AND, -1, -1), a, b, a & b);
    alu_entry("lui", make_info(C_ALU, OP_LUI, -1, -1), a, 64'hffff_ffff_8765_4000,
              64'hffff_ffff_8765_4000);
    alu_entry("mul", make_info(C_MDU, OP_MUL, -1, -1), a, b, a * b);
    alu_entry("mulw", make_info(C_MDU, OP_MUL, OP_MWOP, -1), a, b,
              sign_extend_word(a[31:0] * b[31:0]));
    alu_entry("slt_neg", make_info(C_ALU, OP_SLT, -1, -1), neg, pos,
              {63'd0, $signed(neg) < $signed(pos)});
    alu_entry("slt_pos", make_info(C_ALU, OP_SLT, -1, -1), pos, neg,
              {63'd0, $signed(pos) < $signed(neg)});
    alu_entry("sltu_wrap", make_info(C_ALU, OP_SLTU, -1, -1), neg, pos, {63'd0, neg < pos});
    alu_entry("sltu_lt", make_info(C_ALU, OP_SLTU, -1, -1), pos, neg, {63'd0, pos < neg});

    // shift amounts 0, 31 and 63
    alu_entry("sll_63", make_info(C_ALU, OP_SLL, -1, -1), sa, 64'd63, sa << 63);
    alu_entry("srl_31", make_info(C_ALU, OP_SRL, -1, -1), sa, 64'd31, sa >> 31);
    alu_entry("sra_63", make_info(C_ALU, OP_SRA, -1, -1), sa, 64'd63, $signed(sa) >>> 63);
    alu_entry("sra_0", make_info(C_ALU, OP_SRA, -1, -1), sa, 64'd0, sa);
    alu_entry("sllw_31", make_info(C_ALU, OP_SLL, OP_WOP, -1), sa, 64'd31,
              sign_extend_word(sa[31:0] << 31));
    alu_entry("srlw_0", make_info(C_ALU, OP_SRL, OP_WOP, -1), sa, 64'd0,
              sign_extend_word(sa[31:0]));
    alu_entry("sraw_31", make_info(C_ALU, OP_SRA, OP_WOP, -1), sa, 64'd31,
              sign_extend_word($signed(sa[31:0]) >>> 31));

    branch_entry("beq_taken", OP_BEQ, a, a, a == a);
    branch_entry("beq_not", OP_BEQ, a, b, a == b);
    branch_entry("bne_taken", OP_BNE, a, b, a != b);
    branch_entry("bne_not", OP_BNE, a, a, a != a);
    branch_entry("blt_taken", OP_BLT, neg, pos, $signed(neg) < $signed(pos));
    branch_entry("blt_not", OP_BLT, pos, neg, $signed(pos) < $signed(neg));
    branch_entry("bge_taken", OP_BGE, pos, neg, $signed(pos) >= $signed(neg));
    branch_entry("bge_not", OP_BGE, neg, pos, $signed(neg) >= $signed(pos));
    branch_entry("bltu_taken", OP_BLTU, pos, neg, pos < neg);
    branch_entry("bltu_not", OP_BLTU, neg, pos, neg < pos);
    branch_entry("bgeu_taken", OP_BGEU, neg, pos, neg >= pos);
    branch_entry("bgeu_not", OP_BGEU, pos, neg, pos >= neg);

    // link value is pc + 4 from the adder
    put_entry("jal", make_info(C_BJP, OP_JAL, -1, -1), pc, 64'd4, pc, 64'h800, 5'd1,
              pc + 64'd4, 1'b1, pc + 64'h800, 7'd0, 64'd0, 1'b0);
    put_entry("jalr", make_info(C_BJP, OP_JALR, -1, -1), pc, 64'd4, rs1, 64'h10, 5'd1,
              pc + 64'd4, 1'b1, (rs1 + 64'h10) & ~64'd1, 7'd0, 64'd0, 1'b0);

    // ls_info is {dword, word, half, byte, usign, store, load}
    put_entry("ld", make_info(C_LS, OP_LOAD, OP_DWORD, -1), base, 64'h18, 64'd0, 64'h5555,
              5'd10, base + 64'h18, 1'b0, 64'h5555, 7'b100_0001, 64'd0, 1'b0);
    put_entry("lbu", make_info(C_LS, OP_LOAD, OP_USIGN, OP_BYTE), base, 64'h7, 64'd0,
              64'h77, 5'd11, base + 64'h7, 1'b0, 64'h77, 7'b000_1101, 64'd0, 1'b0);
    put_entry("sw", make_info(C_LS, OP_STORE, OP_WORD, -1), base, 64'h20, 64'd0, data,
              5'd0, base + 64'h20, 1'b0, data, 7'b010_0010, data, 1'b0);

    put_entry("bad_class", make_info(C_BAD, OP_ADD, -1, -1), 64'd7, 64'd9, 64'd0, 64'd0,
              5'd3, 64'd0, 1'b0, 64'd0, 7'd0, 64'd0, 1'b1);
    put_entry("div", make_info(C_MDU, OP_DIV, -1, -1), 64'd100, 64'd7, 64'd0, 64'd0,
              5'd4, 64'd0, 1'b0, 64'd0, 7'd0, 64'd0, 1'b1);
  endtask

  task automatic issue_entry(input int idx);
    issue_valid_i = 1'b1;
    info_i        = t_info[idx];
    op1_i         = t_op1[idx];
    op2_i         = t_op2[idx];
    jp_op1_i      = t_jp1[idx];
    jp_op2_i      = t_jp2[idx];
    rd_idx_i      = t_rd[idx];
    rd_wr_en_i    = (t_rd[idx] != 5'd0);
  endtask

  // compares one writeback beat with its row and reports the first mismatch
  task automatic check_beat(input int idx);
    logic        bad;
    string       field;
    logic [63:0] exp_v;
    logic [63:0] act_v;
    bad = 1'b0;
    if (wb_rd_idx_o !== t_rd[idx]) begin
      bad   = 1'b1;
      field = "rd";
      exp_v = 64'(t_rd[idx]);
      act_v = 64'(wb_rd_idx_o);
    end
    if (!bad && wb_rd_wr_en_o !== (t_rd[idx] != 5'd0)) begin
      bad   = 1'b1;
      field = "rd_wr_en";
      exp_v = 64'(t_rd[idx] != 5'd0);
      act_v = 64'(wb_rd_wr_en_o);
    end
    // result of an illegal op is don't care
    if (!bad && !t_ill[idx] && wb_result_o !== t_res[idx]) begin
      bad   = 1'b1;
      field = "result";
      exp_v = t_res[idx];
      act_v = wb_result_o;
    end
    if (!bad && wb_jump_o !== t_jump[idx]) begin
      bad   = 1'b1;
      field = "jump";
      exp_v = 64'(t_jump[idx]);
      act_v = 64'(wb_jump_o);
    end
    if (!bad && wb_jump_addr_o !== t_tgt[idx]) begin
      bad   = 1'b1;
      field = "target";
      exp_v = t_tgt[idx];
      act_v = wb_jump_addr_o;
    end
    if (!bad && wb_ls_info_o !== t_ls[idx]) begin
      bad   = 1'b1;
      field = "ls_info";
      exp_v = 64'(t_ls[idx]);
      act_v = 64'(wb_ls_info_o);
    end
    if (!bad && wb_store_data_o !== t_sd[idx]) begin
      bad   = 1'b1;
      field = "store_data";
      exp_v = t_sd[idx];
      act_v = wb_store_data_o;
    end
    if (!bad && wb_illegal_o !== t_ill[idx]) begin
      bad   = 1'b1;
      field = "illegal";
      exp_v = 64'(t_ill[idx]);
      act_v = 64'(wb_illegal_o);
    end
    if (bad) begin
      $display("error %s: %s expected %h actual %h", t_name[idx], field, exp_v, act_v);
      failed++;
    end else begin
      $display("ok    %s", t_name[idx]);
      passed++;
    end
  endtask

  initial begin
    clk           = 1'b0;
    reset_i       = 1'b1;
    issue_valid_i = 1'b0;
    rd_wr_en_i    = 1'b0;
    rd_idx_i      = '0;
    op1_i         = '0;
    op2_i         = '0;
    jp_op1_i      = '0;
    jp_op2_i      = '0;
    info_i        = '0;
    wb_credit_i   = 1'b0;
    seed          = 32'hea25_f13f;
    n_tests       = 0;
    next_issue    = 0;
    exp_idx       = 0;
    passed        = 0;
    failed        = 0;
    other_errs    = 0;
    issue_credits = QUEUE_DEPTH;
    outstanding   = 0;
    credit_pulses = 0;
    cycle         = 0;
    tail          = 0;
    timed_out     = 1'b0;
    load_table();
    limit = n_tests * 20;

    repeat (2) @(posedge clk);
    @(negedge clk);
    if (wb_valid_o !== 1'b0 || issue_credit_o !== 1'b0) begin
      $display("wb_valid_o or issue_credit_o is not low right after reset");
      other_errs++;
    end
    reset_i = 1'b0;

    // tail lets the last issue_credit_o pulse arrive
    while (tail < 3 && !timed_out) begin
      @(negedge clk);
      cycle++;
      if (issue_credit_o) begin
        issue_credits++;
        credit_pulses++;
      end
      if (wb_valid_o) begin
        if (outstanding >= WB_CREDITS) begin
          $display("wb_valid_o high without a downstream credit in cycle %0d", cycle);
          other_errs++;
        end
        if (exp_idx < n_tests) begin
          check_beat(exp_idx);
          exp_idx++;
        end else begin
          $display("writeback beat after the last test in cycle %0d", cycle);
          other_errs++;
        end
      end

      // writeback hands back credits of earlier pops at random
      wb_credit_i = 1'b0;
      if (outstanding > 0 && ($random(seed) & 1) != 0) begin
        wb_credit_i = 1'b1;
        outstanding--;
      end
      if (wb_valid_o)
        outstanding++;

      if (next_issue < n_tests && issue_credits > 0) begin
        issue_entry(next_issue);
        issue_credits--;
        next_issue++;
      end else begin
        issue_valid_i = 1'b0;
      end

      if (exp_idx == n_tests)
        tail++;
      if (cycle >= limit)
        timed_out = 1'b1;
    end

    if (timed_out)
      $display("timeout after %0d cycles, %0d of %0d results seen", cycle, exp_idx, n_tests);
    if (credit_pulses != n_tests) begin
      $display("issue_credit_o pulsed %0d times for %0d tests", credit_pulses, n_tests);
      other_errs++;
    end
    $display("tests run %0d, ok %0d, wrong %0d, other errors %0d",
             exp_idx, passed, failed, other_errs);
    if (!timed_out && failed == 0 && other_errs == 0 && exp_idx == n_tests) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
